// File: decode.f
+incdir+tests
src/decode_pkg.sv
src/pipe_stage.sv
src/imm_gen.sv
src/riscv_decoder.sv
src/decode_unit.sv
tests/decode_checker.sv
tests/decode_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f decode.f --top-module decode_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vdecode_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

// File: tests/decode_vectors.svh
// name, mode64, insn, pc, insn_pred, insn_pred_target,
// op, dst, {dst_valid, src_a_valid, src_b_valid}, pc_rel, imm, flags
task load_vectors;
	add_vec("addi", 1'b1, 32'hffd30293, 64'h1000, 1'b0, 64'h0,
		ADDI, 6'd5, 3'b110, 1'b0, 64'hffff_ffff_ffff_fffd, 8'h0c);
	add_vec("addi_x0_nop", 1'b1, 32'h00530013, 64'h1000, 1'b0, 64'h0,
		NOP, 6'd0, 3'b000, 1'b0, 64'd5, 8'h0c);
	add_vec("sub", 1'b1, 32'h409403b3, 64'h1000, 1'b0, 64'h0,
		SUBU, 6'd7, 3'b111, 1'b0, 64'd0, 8'h0c);
	add_vec("srai", 1'b1, 32'h40725193, 64'h1000, 1'b0, 64'h0,
		SRAI, 6'd3, 3'b110, 1'b0, 64'h407, 8'h0c);
	add_vec("mul", 1'b1, 32'h02c58533, 64'h1000, 1'b0, 64'h0,
		MUL, 6'd10, 3'b111, 1'b0, 64'd0, 8'h08);
	add_vec("divu", 1'b1, 32'h02f756b3, 64'h1000, 1'b0, 64'h0,
		DIVU, 6'd13, 3'b111, 1'b0, 64'd0, 8'h08);
	add_vec("ld", 1'b1, 32'hff813283, 64'h1000, 1'b0, 64'h0,
		LD, 6'd5, 3'b110, 1'b0, 64'hffff_ffff_ffff_fff8, 8'h20);
	add_vec("lbu", 1'b1, 32'h0101c303, 64'h1000, 1'b0, 64'h0,
		LBU, 6'd6, 3'b110, 1'b0, 64'd16, 8'h20);
	add_vec("sd", 1'b1, 32'hfe713823, 64'h1000, 1'b0, 64'h0,
		SD, 6'd0, 3'b011, 1'b0, 64'hffff_ffff_ffff_fff0, 8'h30);
	add_vec("sw", 1'b1, 32'h0084aa23, 64'h1000, 1'b0, 64'h0,
		SW, 6'd0, 3'b011, 1'b0, 64'd20, 8'h30);
	add_vec("auipc", 1'b1, 32'h12345297, 64'h1000, 1'b0, 64'h0,
		AUIPC, 6'd5, 3'b100, 1'b1, 64'h1234_5000, 8'h0c);
	add_vec("auipc_rv32", 1'b0, 32'h7ffff317, 64'h1000, 1'b0, 64'h0,
		AUIPC, 6'd6, 3'b100, 1'b1, 64'h7fff_f000, 8'h0c);
	add_vec("beq_pred", 1'b1, 32'hfe208ce3, 64'h1000, 1'b1, 64'h0,
		BEQ, 6'd0, 3'b011, 1'b1, 64'hffff_ffff_ffff_fff8, 8'hcc);
	add_vec("bne_rv32", 1'b0, 32'h00419863, 64'h7fff_fff8, 1'b0, 64'h0,
		BNE, 6'd0, 3'b011, 1'b1, 64'd16, 8'h4c);
	add_vec("jal", 1'b1, 32'h001000ef, 64'h1000, 1'b0, 64'h0,
		JAL, 6'd1, 3'b100, 1'b1, 64'h800, 8'hcc);
	add_vec("j", 1'b1, 32'hffdff06f, 64'h1000, 1'b0, 64'h0,
		J, 6'd0, 3'b000, 1'b1, 64'hffff_ffff_ffff_fffc, 8'hc8);
	add_vec("ret_x1", 1'b1, 32'h00008067, 64'h1000, 1'b1, 64'h0040_1000,
		RET, 6'd0, 3'b010, 1'b0, 64'd0, 8'hcc);
	add_vec("ret_x5", 1'b1, 32'h00028067, 64'h1000, 1'b1, 64'h0040_2000,
		RET, 6'd0, 3'b010, 1'b0, 64'd0, 8'hcc);
	add_vec("jr", 1'b1, 32'h00430067, 64'h1000, 1'b1, 64'h0040_3000,
		JR, 6'd0, 3'b010, 1'b0, 64'd4, 8'hcc);
	add_vec("jalr", 1'b1, 32'h000380e7, 64'h1000, 1'b1, 64'h0040_4000,
		JALR, 6'd1, 3'b110, 1'b0, 64'd0, 8'hcc);
	add_vec("addw_rv32", 1'b0, 32'h007302bb, 64'h1000, 1'b0, 64'h0,
		II, 6'd0, 3'b000, 1'b0, 64'd0, 8'h00);
	add_vec("addw_rv64", 1'b1, 32'h007302bb, 64'h1000, 1'b0, 64'h0,
		ADDW, 6'd5, 3'b111, 1'b0, 64'd0, 8'h0c);
	add_vec("rdcycleh_rv32", 1'b0, 32'hc80022f3, 64'h1000, 1'b0, 64'h0,
		RDCYCLEH, 6'd5, 3'b100, 1'b0, 64'd0, 8'h0a);
	add_vec("csr_c80_rv64", 1'b1, 32'hc80022f3, 64'h1000, 1'b0, 64'h0,
		NOP, 6'd0, 3'b000, 1'b0, 64'd0, 8'h08);
	add_vec("rdcycle", 1'b1, 32'hc0002373, 64'h1000, 1'b0, 64'h0,
		RDCYCLE, 6'd6, 3'b100, 1'b0, 64'd0, 8'h0a);
	add_vec("break", 1'b1, 32'h00000073, 64'h1000, 1'b0, 64'h0,
		BREAK, 6'd0, 3'b000, 1'b0, 64'd0, 8'h0a);
	add_vec("monitor", 1'b1, 32'h00100073, 64'h1000, 1'b0, 64'h0,
		MONITOR, 6'd0, 3'b000, 1'b0, 64'd0, 8'h0b);
	add_vec("illegal", 1'b1, 32'h0000007f, 64'h1000, 1'b0, 64'h0,
		II, 6'd0, 3'b000, 1'b0, 64'd0, 8'h00);
endtask

// File: tests/decode_tb.sv
module decode_tb;
	import decode_pkg::*;

	typedef struct packed {
		logic mode64;
		logic [31:0] insn;
		logic [M_WIDTH-1:0] pc;
		logic pred;
		logic [M_WIDTH-1:0] pred_target;
		op_t op;
		logic [LG_PRF_ENTRIES-1:0] dst;
		logic [2:0] valids; // dst, src_a, src_b
		logic pc_rel; // rvimm is pc plus imm
		logic [M_WIDTH-1:0] imm;
		logic [7:0] flags; // br_pred is_br mem store int cheap serializing restart
	} vec_t;

	logic clk = 1'b0;
	logic arst_n;
	logic flush;
	logic mode64;
	logic insn_valid;
	logic [31:0] insn;
	logic [M_WIDTH-1:0] pc;
	logic insn_pred;
	logic [LG_PHT_SZ-1:0] pht_idx;
	logic [M_WIDTH-1:0] insn_pred_target;
	logic uop_valid;
	op_t uop_op;
	logic [LG_PRF_ENTRIES-1:0] uop_src_a;
	logic [LG_PRF_ENTRIES-1:0] uop_src_b;
	logic [LG_PRF_ENTRIES-1:0] uop_dst;
	logic uop_src_a_valid;
	logic uop_src_b_valid;
	logic uop_dst_valid;
	logic [M_WIDTH-1:0] uop_rvimm;
	logic [M_WIDTH-1:0] uop_jmp_target;
	logic [M_WIDTH-1:0] uop_pc;
	logic [LG_PHT_SZ-1:0] uop_pht_idx;
	logic uop_br_pred;
	logic uop_is_br;
	logic uop_is_mem;
	logic uop_is_store;
	logic uop_is_int;
	logic uop_is_cheap_int;
	logic uop_serializing;
	logic uop_must_restart;

	vec_t vecs[$];
	string names[$];
	integer seed;
	integer errors;
	integer tests;
	integer test_errs;

	always #5 clk = ~clk;

	decode_unit u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.mode64(mode64),
		.insn_valid(insn_valid),
		.insn(insn),
		.pc(pc),
		.insn_pred(insn_pred),
		.pht_idx(pht_idx),
		.insn_pred_target(insn_pred_target),
		.uop_valid(uop_valid),
		.uop_op(uop_op),
		.uop_src_a(uop_src_a),
		.uop_src_b(uop_src_b),
		.uop_dst(uop_dst),
		.uop_src_a_valid(uop_src_a_valid),
		.uop_src_b_valid(uop_src_b_valid),
		.uop_dst_valid(uop_dst_valid),
		.uop_rvimm(uop_rvimm),
		.uop_jmp_target(uop_jmp_target),
		.uop_pc(uop_pc),
		.uop_pht_idx(uop_pht_idx),
		.uop_br_pred(uop_br_pred),
		.uop_is_br(uop_is_br),
		.uop_is_mem(uop_is_mem),
		.uop_is_store(uop_is_store),
		.uop_is_int(uop_is_int),
		.uop_is_cheap_int(uop_is_cheap_int),
		.uop_serializing(uop_serializing),
		.uop_must_restart(uop_must_restart)
	);

	task automatic add_vec(input string name, input logic m64, input logic [31:0] insn_w,
		input logic [M_WIDTH-1:0] pc_w, input logic pred, input logic [M_WIDTH-1:0] tgt,
		input op_t op, input logic [LG_PRF_ENTRIES-1:0] dst, input logic [2:0] valids,
		input logic rel, input logic [M_WIDTH-1:0] imm, input logic [7:0] flags);
		vec_t v;
		v = '{m64, insn_w, pc_w, pred, tgt, op, dst, valids, rel, imm, flags};
		vecs.push_back(v);
		names.push_back(name);
	endtask

	`include "decode_vectors.svh"

	// rv32 results wrap at 32 bits and come out sign-extended
	function automatic logic [M_WIDTH-1:0] expected_rvimm(vec_t v, logic [M_WIDTH-1:0] pc_v);
		logic [M_WIDTH-1:0] sum;
		if (!v.pc_rel)
			return v.imm;
		sum = pc_v + v.imm;
		if (v.mode64)
			return sum;
		return {{32{sum[31]}}, sum[31:0]};
	endfunction

	task automatic check_value(input string test, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		assert (expected === actual)
		else
		begin
			$display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
			errors = errors + 1;
			test_errs = test_errs + 1;
		end
	endtask

	task automatic check_uop(input int idx, input logic [M_WIDTH-1:0] pc_v,
		input logic [LG_PHT_SZ-1:0] pht_v);
		vec_t v;
		string n;
		logic [7:0] act_flags;
		v = vecs[idx];
		n = names[idx];
		act_flags = {uop_br_pred, uop_is_br, uop_is_mem, uop_is_store, uop_is_int,
			uop_is_cheap_int, uop_serializing, uop_must_restart};
		check_value(n, "op", 64'(v.op), 64'(uop_op));
		check_value(n, "dst", 64'(v.dst), 64'(uop_dst));
		check_value(n, "valids", 64'(v.valids),
			64'({uop_dst_valid, uop_src_a_valid, uop_src_b_valid}));
		if (v.valids[1])
			check_value(n, "src_a", 64'(v.insn[19:15]), 64'(uop_src_a));
		if (v.valids[0])
			check_value(n, "src_b", 64'(v.insn[24:20]), 64'(uop_src_b));
		check_value(n, "rvimm", expected_rvimm(v, pc_v), uop_rvimm);
		check_value(n, "flags", 64'(v.flags), 64'(act_flags));
		check_value(n, "pc", pc_v, uop_pc);
		check_value(n, "pht_idx", 64'(pht_v), 64'(uop_pht_idx));
		if (v.op == RET || v.op == JR || v.op == JALR)
			check_value(n, "jmp_target", v.pred_target, uop_jmp_target);
	endtask

	task automatic drive_row(input int idx, input logic [M_WIDTH-1:0] pc_v,
		input logic [LG_PHT_SZ-1:0] pht_v);
		insn_valid <= 1'b1;
		insn <= vecs[idx].insn;
		pc <= pc_v;
		insn_pred <= vecs[idx].pred;
		pht_idx <= pht_v;
		insn_pred_target <= vecs[idx].pred_target;
	endtask

	task automatic wait_uop(input string what, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < 20)
		begin
			@(negedge clk);
			seen = uop_valid;
			n = n + 1;
		end
		if (!seen)
		begin
			$display("timeout: uop_valid never appeared for %s within 20 cycles", what);
			errors = errors + 1;
			test_errs = test_errs + 1;
		end
	endtask

	task automatic finish_test(input string name);
		tests = tests + 1;
		if (test_errs == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	// back to back rows of one mode, each uop due two edges after its drive edge
	task automatic stream_mode(input logic m64, input string name);
		int idx_q[$];
		logic [M_WIDTH-1:0] pc_q[$];
		logic [M_WIDTH-1:0] pc_v;
		int n;
		int k;
		for (int i = 0; i < vecs.size(); i++)
		begin
			if (vecs[i].mode64 == m64)
			begin
				pc_v = vecs[i].pc;
				if (vecs[i].pc_rel)
				begin
					pc_v[63:32] = $random(seed);
					pc_v[31:0] = $random(seed);
					pc_v[1:0] = 2'b00;
				end
				idx_q.push_back(i);
				pc_q.push_back(pc_v);
			end
		end
		n = idx_q.size();
		@(posedge clk);
		mode64 <= m64;
		for (int c = 0; c < n + 3; c++)
		begin
			@(posedge clk);
			if (c < n)
				drive_row(idx_q[c], pc_q[c], 10'(c));
			else
				insn_valid <= 1'b0;
			@(negedge clk);
			k = c - 2;
			if (k >= 0 && k < n)
			begin
				assert (uop_valid)
				else
				begin
					$display("%s: no uop two cycles after input of %s", name, names[idx_q[k]]);
					errors = errors + 1;
					test_errs = test_errs + 1;
				end
				if (uop_valid)
					check_uop(idx_q[k], pc_q[k], 10'(k));
			end
			else
			begin
				assert (!uop_valid)
				else
				begin
					$display("%s: unexpected uop_valid at stream cycle %0d", name, c);
					errors = errors + 1;
					test_errs = test_errs + 1;
				end
			end
		end
		finish_test(name);
	endtask

	initial
	begin
		bit seen;
		seed = 14;
		errors = 0;
		tests = 0;
		test_errs = 0;
		arst_n = 1'b1;
		flush = 1'b0;
		mode64 = 1'b1;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		insn_pred_target = '0;
		load_vectors();
		#1 arst_n = 1'b0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		for (int c = 0; c < 5; c++)
		begin
			@(negedge clk);
			assert (!uop_valid)
			else
			begin
				$display("reset: uop_valid high before any input");
				errors = errors + 1;
				test_errs = test_errs + 1;
			end
		end
		finish_test("reset_idle");

		for (int i = 0; i < vecs.size(); i++)
		begin
			@(posedge clk);
			mode64 <= vecs[i].mode64;
			drive_row(i, vecs[i].pc, 10'(i));
			@(posedge clk);
			insn_valid <= 1'b0;
			wait_uop(names[i], seen);
			if (seen)
				check_uop(i, vecs[i].pc, 10'(i));
			finish_test(names[i]);
		end

		stream_mode(1'b1, "stream_rv64");
		stream_mode(1'b0, "stream_rv32");

		// first row sits in stage 1, second arrives with flush
		@(posedge clk);
		mode64 <= 1'b1;
		drive_row(0, vecs[0].pc, 10'd1);
		@(posedge clk);
		drive_row(2, vecs[2].pc, 10'd2);
		flush <= 1'b1;
		@(posedge clk);
		insn_valid <= 1'b0;
		flush <= 1'b0;
		for (int c = 0; c < 6; c++)
		begin
			@(negedge clk);
			assert (!uop_valid)
			else
			begin
				$display("flush: uop_valid appeared for a flushed instruction");
				errors = errors + 1;
				test_errs = test_errs + 1;
			end
		end
		@(posedge clk);
		drive_row(3, vecs[3].pc, 10'd3);
		@(posedge clk);
		insn_valid <= 1'b0;
		wait_uop("flush_recovery", seen);
		if (seen)
			check_uop(3, vecs[3].pc, 10'd3);
		finish_test("flush");

		$display("tests run: %0d, failed checks: %0d, assertion failures: %0d",
			tests, errors, u_dut.u_checker.fail_count);
		if (errors == 0 && u_dut.u_checker.fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: tests/decode_checker.sv
module decode_checker (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic insn_valid,
	input logic uop_valid,
	input logic uop_is_store,
	input logic uop_is_mem,
	input logic uop_dst_valid,
	input logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_dst
);

	int fail_count = 0;

	reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !uop_valid)
	else
	begin
		$error("uop_valid high while in reset");
		fail_count = fail_count + 1;
	end

	// two stages, nothing flushed on the way
	uop_latency: assert property (@(posedge clk) disable iff (!arst_n)
		uop_valid |-> $past(insn_valid, 2) && !$past(flush, 1) && !$past(flush, 2))
	else
	begin
		$error("uop_valid without a matching unflushed input two cycles earlier");
		fail_count = fail_count + 1;
	end

	store_is_mem: assert property (@(posedge clk) disable iff (!arst_n)
		uop_valid && uop_is_store |-> uop_is_mem)
	else
	begin
		$error("store uop without is_mem");
		fail_count = fail_count + 1;
	end

	dst_not_x0: assert property (@(posedge clk) disable iff (!arst_n)
		uop_valid && uop_dst_valid |-> uop_dst != '0)
	else
	begin
		$error("valid destination is x0");
		fail_count = fail_count + 1;
	end

endmodule

bind decode_unit decode_checker u_checker (
	.clk(clk),
	.arst_n(arst_n),
	.flush(flush),
	.insn_valid(insn_valid),
	.uop_valid(uop_valid),
	.uop_is_store(uop_is_store),
	.uop_is_mem(uop_is_mem),
	.uop_dst_valid(uop_dst_valid),
	.uop_dst(uop_dst)
);

// File: src/decode_unit.sv
module decode_unit (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic mode64,
	input logic insn_valid,
	input logic [31:0] insn,
	input logic [decode_pkg::M_WIDTH-1:0] pc,
	input logic insn_pred,
	input logic [decode_pkg::LG_PHT_SZ-1:0] pht_idx,
	input logic [decode_pkg::M_WIDTH-1:0] insn_pred_target,
	output logic uop_valid,
	output decode_pkg::op_t uop_op,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_src_a,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_src_b,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_dst,
	output logic uop_src_a_valid,
	output logic uop_src_b_valid,
	output logic uop_dst_valid,
	output logic [decode_pkg::M_WIDTH-1:0] uop_rvimm,
	output logic [decode_pkg::M_WIDTH-1:0] uop_jmp_target,
	output logic [decode_pkg::M_WIDTH-1:0] uop_pc,
	output logic [decode_pkg::LG_PHT_SZ-1:0] uop_pht_idx,
	output logic uop_br_pred,
	output logic uop_is_br,
	output logic uop_is_mem,
	output logic uop_is_store,
	output logic uop_is_int,
	output logic uop_is_cheap_int,
	output logic uop_serializing,
	output logic uop_must_restart
);
	import decode_pkg::*;

	fetch_bundle_t fetch_in;
	fetch_bundle_t fetch_q;
	logic fetch_valid;
	logic [M_WIDTH-1:0] pc_imm;
	uop_bundle_t uop_d;
	uop_bundle_t uop_q;

	assign fetch_in = '{
		insn: insn,
		pc: pc,
		insn_pred: insn_pred,
		pht_idx: pht_idx,
		insn_pred_target: insn_pred_target
	};

	pipe_stage #(
		.payload_t(fetch_bundle_t)
	) u_fetch_stage (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.in_valid(insn_valid),
		.in_data(fetch_in),
		.out_valid(fetch_valid),
		.out_data(fetch_q)
	);

	imm_gen u_imm_gen (
		.mode64(mode64),
		.insn(fetch_q.insn),
		.pc(fetch_q.pc),
		.pc_imm(pc_imm)
	);

	riscv_decoder u_decoder (
		.mode64(mode64),
		.insn(fetch_q.insn),
		.pc(fetch_q.pc),
		.insn_pred(fetch_q.insn_pred),
		.pht_idx(fetch_q.pht_idx),
		.insn_pred_target(fetch_q.insn_pred_target),
		.pc_imm(pc_imm),
		.uop_op(uop_d.op),
		.uop_src_a(uop_d.src_a),
		.uop_src_b(uop_d.src_b),
		.uop_dst(uop_d.dst),
		.uop_src_a_valid(uop_d.src_a_valid),
		.uop_src_b_valid(uop_d.src_b_valid),
		.uop_dst_valid(uop_d.dst_valid),
		.uop_rvimm(uop_d.rvimm),
		.uop_jmp_target(uop_d.jmp_target),
		.uop_pc(uop_d.pc),
		.uop_pht_idx(uop_d.pht_idx),
		.uop_br_pred(uop_d.br_pred),
		.uop_is_br(uop_d.is_br),
		.uop_is_mem(uop_d.is_mem),
		.uop_is_store(uop_d.is_store),
		.uop_is_int(uop_d.is_int),
		.uop_is_cheap_int(uop_d.is_cheap_int),
		.uop_serializing(uop_d.serializing),
		.uop_must_restart(uop_d.must_restart)
	);

	pipe_stage #(
		.payload_t(uop_bundle_t)
	) u_uop_stage (
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.in_valid(fetch_valid),
		.in_data(uop_d),
		.out_valid(uop_valid),
		.out_data(uop_q)
	);

	// to rename
	assign uop_op = uop_q.op;
	assign uop_src_a = uop_q.src_a;
	assign uop_src_b = uop_q.src_b;
	assign uop_dst = uop_q.dst;
	assign uop_src_a_valid = uop_q.src_a_valid;
	assign uop_src_b_valid = uop_q.src_b_valid;
	assign uop_dst_valid = uop_q.dst_valid;
	assign uop_rvimm = uop_q.rvimm;
	assign uop_jmp_target = uop_q.jmp_target;
	assign uop_pc = uop_q.pc;
	assign uop_pht_idx = uop_q.pht_idx;
	assign uop_br_pred = uop_q.br_pred;
	assign uop_is_br = uop_q.is_br;
	assign uop_is_mem = uop_q.is_mem;
	assign uop_is_store = uop_q.is_store;
	assign uop_is_int = uop_q.is_int;
	assign uop_is_cheap_int = uop_q.is_cheap_int;
	assign uop_serializing = uop_q.serializing;
	assign uop_must_restart = uop_q.must_restart;

endmodule

// File: src/riscv_decoder.sv
module riscv_decoder (
	input logic mode64,
	input logic [31:0] insn,
	input logic [decode_pkg::M_WIDTH-1:0] pc,
	input logic insn_pred,
	input logic [decode_pkg::LG_PHT_SZ-1:0] pht_idx,
	input logic [decode_pkg::M_WIDTH-1:0] insn_pred_target,
	input logic [decode_pkg::M_WIDTH-1:0] pc_imm,
	output decode_pkg::op_t uop_op,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_src_a,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_src_b,
	output logic [decode_pkg::LG_PRF_ENTRIES-1:0] uop_dst,
	output logic uop_src_a_valid,
	output logic uop_src_b_valid,
	output logic uop_dst_valid,
	output logic [decode_pkg::M_WIDTH-1:0] uop_rvimm,
	output logic [decode_pkg::M_WIDTH-1:0] uop_jmp_target,
	output logic [decode_pkg::M_WIDTH-1:0] uop_pc,
	output logic [decode_pkg::LG_PHT_SZ-1:0] uop_pht_idx,
	output logic uop_br_pred,
	output logic uop_is_br,
	output logic uop_is_mem,
	output logic uop_is_store,
	output logic uop_is_int,
	output logic uop_is_cheap_int,
	output logic uop_serializing,
	output logic uop_must_restart
);
	import decode_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [LG_PRF_ENTRIES-1:0] rd;
	logic [LG_PRF_ENTRIES-1:0] rs1;
	logic [LG_PRF_ENTRIES-1:0] rs2;
	logic rd_nz;
	logic rs1_is_link;
	logic [M_WIDTH-1:0] i_imm;
	logic [M_WIDTH-1:0] s_imm;
	logic x0_nop; // result to x0 turns into nop

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];
	assign rd = {{(LG_PRF_ENTRIES - 5){1'b0}}, insn[11:7]};
	assign rs1 = {{(LG_PRF_ENTRIES - 5){1'b0}}, insn[19:15]};
	assign rs2 = {{(LG_PRF_ENTRIES - 5){1'b0}}, insn[24:20]};
	assign rd_nz = (insn[11:7] != 5'd0);
	assign rs1_is_link = (insn[19:15] == 5'd1) || (insn[19:15] == 5'd5);
	assign i_imm = {{(PAD_W + 20){insn[31]}}, insn[31:20]};
	assign s_imm = {{(PAD_W + 20){insn[31]}}, insn[31:25], insn[11:7]};

	always_comb
	begin
		uop_op = II;
		uop_src_a = '0;
		uop_src_b = '0;
		uop_dst = '0;
		uop_src_a_valid = 1'b0;
		uop_src_b_valid = 1'b0;
		uop_dst_valid = 1'b0;
		uop_rvimm = '0;
		uop_jmp_target = '0;
		uop_pc = pc;
		uop_pht_idx = pht_idx;
		uop_br_pred = 1'b0;
		uop_is_br = 1'b0;
		uop_is_mem = 1'b0;
		uop_is_store = 1'b0;
		uop_is_int = 1'b0;
		uop_is_cheap_int = 1'b0;
		uop_serializing = 1'b0;
		uop_must_restart = 1'b0;
		x0_nop = 1'b0;

		case (opcode)
			OPC_LOAD:
			begin
				uop_dst = rd;
				uop_src_a = rs1;
				uop_dst_valid = rd_nz;
				uop_src_a_valid = 1'b1;
				uop_is_mem = 1'b1;
				uop_rvimm = i_imm;
				case (funct3)
					3'd0: uop_op = LB;
					3'd1: uop_op = LH;
					3'd2: uop_op = LW;
					3'd3: uop_op = LD;
					3'd4: uop_op = LBU;
					3'd5: uop_op = LHU;
					3'd6: uop_op = LWU;
					default: uop_op = II;
				endcase
			end
			OPC_MISC_MEM:
			begin
				uop_op = NOP; // fence
			end
			OPC_OP_IMM:
			begin
				uop_dst = rd;
				uop_src_a = rs1;
				uop_dst_valid = rd_nz;
				uop_src_a_valid = rd_nz;
				uop_is_int = 1'b1;
				uop_is_cheap_int = 1'b1;
				uop_rvimm = i_imm;
				x0_nop = 1'b1;
				case (funct3)
					3'd0: uop_op = ADDI;
					3'd1: uop_op = SLLI;
					3'd2: uop_op = SLTI;
					3'd3: uop_op = SLTIU;
					3'd4: uop_op = XORI;
					3'd5: uop_op = (insn[31:26] == 6'h00) ? SRLI :
						(insn[31:26] == 6'h10) ? SRAI : II;
					3'd6: uop_op = ORI;
					default: uop_op = ANDI;
				endcase
			end
			OPC_AUIPC, OPC_LUI:
			begin
				uop_op = (opcode == OPC_LUI) ? LUI : AUIPC;
				uop_dst = rd;
				uop_dst_valid = rd_nz;
				uop_is_int = 1'b1;
				uop_is_cheap_int = 1'b1;
				uop_rvimm = (opcode == OPC_LUI) ?
					{{PAD_W{insn[31]}}, insn[31:12], 12'd0} : pc_imm;
				x0_nop = 1'b1;
			end
			OPC_OP_IMM_32:
			begin
				if (mode64)
				begin
					uop_dst = rd;
					uop_src_a = rs1;
					uop_dst_valid = rd_nz;
					uop_src_a_valid = rd_nz;
					uop_is_int = 1'b1;
					uop_is_cheap_int = 1'b1;
					uop_rvimm = i_imm;
					x0_nop = 1'b1;
					case (funct3)
						3'd0: uop_op = ADDIW;
						3'd1: uop_op = SLLIW;
						3'd5: uop_op = SRAIW;
						default: uop_op = II;
					endcase
				end
			end
			OPC_STORE:
			begin
				uop_src_a = rs1;
				uop_src_b = rs2;
				uop_src_a_valid = 1'b1;
				uop_src_b_valid = 1'b1;
				uop_is_mem = 1'b1;
				uop_is_store = 1'b1;
				uop_rvimm = s_imm;
				case (funct3)
					3'd0: uop_op = SB;
					3'd1: uop_op = SH;
					3'd2: uop_op = SW;
					3'd3: uop_op = SD;
					default: uop_op = II;
				endcase
			end
			OPC_OP:
			begin
				uop_dst = rd;
				uop_src_a = rs1;
				uop_src_b = rs2;
				uop_dst_valid = rd_nz;
				uop_src_a_valid = 1'b1;
				uop_src_b_valid = 1'b1;
				uop_is_int = 1'b1;
				uop_is_cheap_int = (funct7 != 7'h01); // mul/div are long latency
				x0_nop = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'd0}: uop_op = ADDU;
					{7'h20, 3'd0}: uop_op = SUBU;
					{7'h00, 3'd1}: uop_op = SLL;
					{7'h00, 3'd2}: uop_op = SLT;
					{7'h00, 3'd3}: uop_op = SLTU;
					{7'h00, 3'd4}: uop_op = XOR;
					{7'h00, 3'd5}: uop_op = SRL;
					{7'h20, 3'd5}: uop_op = SRA;
					{7'h00, 3'd6}: uop_op = OR;
					{7'h00, 3'd7}: uop_op = AND;
					{7'h01, 3'd0}: uop_op = MUL;
					{7'h01, 3'd1}: uop_op = MULH;
					{7'h01, 3'd3}: uop_op = MULHU;
					{7'h01, 3'd4}: uop_op = DIV;
					{7'h01, 3'd5}: uop_op = DIVU;
					{7'h01, 3'd6}: uop_op = REM;
					{7'h01, 3'd7}: uop_op = REMU;
					default: uop_op = II;
				endcase
			end
			OPC_OP_32:
			begin
				if (mode64)
				begin
					uop_dst = rd;
					uop_src_a = rs1;
					uop_src_b = rs2;
					uop_dst_valid = rd_nz;
					uop_src_a_valid = 1'b1;
					uop_src_b_valid = 1'b1;
					uop_is_int = 1'b1;
					x0_nop = 1'b1;
					case ({funct7, funct3})
						{7'h00, 3'd0}: uop_op = ADDW;
						{7'h20, 3'd0}: uop_op = SUBW;
						{7'h01, 3'd0}: uop_op = MULW;
						{7'h00, 3'd1}: uop_op = SLLW;
						{7'h01, 3'd4}: uop_op = DIVW;
						{7'h20, 3'd5}: uop_op = SRAW;
						default: uop_op = II;
					endcase
					uop_is_cheap_int = (uop_op == ADDW) || (uop_op == SUBW) || (uop_op == SLLW);
				end
			end
			OPC_BRANCH:
			begin
				uop_src_a = rs1;
				uop_src_b = rs2;
				uop_src_a_valid = 1'b1;
				uop_src_b_valid = 1'b1;
				uop_is_int = 1'b1;
				uop_is_cheap_int = 1'b1;
				uop_is_br = 1'b1;
				uop_br_pred = insn_pred;
				uop_rvimm = pc_imm;
				case (funct3)
					3'd0: uop_op = BEQ;
					3'd1: uop_op = BNE;
					3'd4: uop_op = BLT;
					3'd5: uop_op = BGE;
					3'd6: uop_op = BLTU;
					3'd7: uop_op = BGEU;
					default: uop_op = II;
				endcase
			end
			OPC_JALR:
			begin
				uop_src_a = rs1;
				uop_src_a_valid = 1'b1;
				uop_is_int = 1'b1;
				uop_is_cheap_int = 1'b1;
				uop_is_br = 1'b1;
				uop_br_pred = 1'b1;
				uop_rvimm = i_imm;
				uop_jmp_target = insn_pred_target; // from the btb
				if (!rd_nz)
					uop_op = rs1_is_link ? RET : JR;
				else
				begin
					uop_op = JALR;
					uop_dst = rd;
					uop_dst_valid = 1'b1;
				end
			end
			OPC_JAL:
			begin
				uop_is_int = 1'b1;
				uop_is_br = 1'b1;
				uop_br_pred = 1'b1;
				uop_rvimm = pc_imm;
				if (!rd_nz)
					uop_op = J;
				else
				begin
					uop_op = JAL;
					uop_dst = rd;
					uop_dst_valid = 1'b1;
					uop_is_cheap_int = 1'b1;
				end
			end
			OPC_SYSTEM:
			begin
				uop_is_int = 1'b1;
				uop_op = NOP;
				if (insn[31:7] == 25'd0)
				begin
					uop_op = BREAK;
					uop_serializing = 1'b1;
				end
				else if (insn[31:20] == 12'd1 && insn[19:7] == 13'd0)
				begin
					uop_op = MONITOR;
					uop_serializing = 1'b1;
					uop_must_restart = 1'b1;
				end
				else if (funct3 == 3'd2)
				begin
					case (insn[31:20]) // csrrs counter reads
						12'hc00: uop_op = RDCYCLE;
						12'hc80: uop_op = mode64 ? NOP : RDCYCLEH;
						12'hc02: uop_op = RDINSTRET;
						12'hc82: uop_op = mode64 ? NOP : RDINSTRETH;
						12'hc03: uop_op = RDBRANCH;
						12'hc04: uop_op = mode64 ? NOP : RDFAULTEDBRANCH;
						default: uop_op = NOP;
					endcase
					if (uop_op != NOP)
					begin
						uop_dst = rd;
						uop_dst_valid = rd_nz;
						uop_serializing = 1'b1;
						x0_nop = 1'b1;
					end
				end
			end
			default:
			begin
				uop_op = II;
			end
		endcase

		if (x0_nop && !rd_nz && uop_op != II)
			uop_op = NOP;

		// unknown encodings carry nothing downstream
		if (uop_op == II)
		begin
			uop_src_a_valid = 1'b0;
			uop_src_b_valid = 1'b0;
			uop_dst_valid = 1'b0;
			uop_is_mem = 1'b0;
			uop_is_store = 1'b0;
			uop_is_int = 1'b0;
			uop_is_cheap_int = 1'b0;
			uop_is_br = 1'b0;
			uop_br_pred = 1'b0;
		end
	end

endmodule

// File: src/imm_gen.sv
module imm_gen (
	input logic mode64,
	input logic [31:0] insn,
	input logic [decode_pkg::M_WIDTH-1:0] pc,
	output logic [decode_pkg::M_WIDTH-1:0] pc_imm
);
	import decode_pkg::*;

	logic [6:0] opcode;
	logic [M_WIDTH-1:0] imm;
	logic [M_WIDTH-1:0] sum;

	assign opcode = insn[6:0];

	always_comb
	begin
		imm = '0;
		case (opcode)
			OPC_AUIPC:
			begin
				imm = {{PAD_W{insn[31]}}, insn[31:12], 12'd0};
			end
			OPC_BRANCH:
			begin
				imm = {{(PAD_W + 19){insn[31]}}, insn[31], insn[7], insn[30:25],
					insn[11:8], 1'b0}; // b-type
			end
			OPC_JAL:
			begin
				imm = {{(PAD_W + 11){insn[31]}}, insn[31], insn[19:12], insn[20],
					insn[30:21], 1'b0}; // j-type
			end
			default:
			begin
				imm = '0;
			end
		endcase
	end

	assign sum = pc + imm;

	// rv32 wraps at 32 bits, keep the result sign-extended
	assign pc_imm = mode64 ? sum : {{PAD_W{sum[31]}}, sum[31:0]};

endmodule

// File: src/pipe_stage.sv
module pipe_stage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid & ~flush; // flush drops the incoming one too
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
			out_data <= in_data; // holds while idle
	end

endmodule

// File: src/decode_pkg.sv
package decode_pkg;

	localparam int M_WIDTH = 64;
	localparam int LG_PHT_SZ = 10;
	localparam int LG_PRF_ENTRIES = 6;
	localparam int PAD_W = M_WIDTH - 32; // sign fill above a 32-bit value

	localparam logic [6:0] OPC_LOAD = 7'h03;
	localparam logic [6:0] OPC_MISC_MEM = 7'h0f;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_AUIPC = 7'h17;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'h1b;
	localparam logic [6:0] OPC_STORE = 7'h23;
	localparam logic [6:0] OPC_OP = 7'h33;
	localparam logic [6:0] OPC_LUI = 7'h37;
	localparam logic [6:0] OPC_OP_32 = 7'h3b;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_JALR = 7'h67;
	localparam logic [6:0] OPC_JAL = 7'h6f;
	localparam logic [6:0] OPC_SYSTEM = 7'h73;

	typedef enum logic [7:0] {
		LB, LH, LW, LD, LBU, LHU, LWU,
		SB, SH, SW, SD,
		ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
		ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		MUL, MULH, MULHU, DIV, DIVU, REM, REMU,
		ADDIW, SLLIW, SRAIW, ADDW, SUBW, MULW, SLLW, DIVW, SRAW,
		LUI, AUIPC,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		J, JAL, JR, JALR, RET,
		BREAK, MONITOR, RDCYCLE, RDCYCLEH, RDINSTRET, RDINSTRETH,
		RDBRANCH, RDFAULTEDBRANCH,
		NOP,
		II // unknown encoding
	} op_t;

	typedef struct packed {
		logic [31:0] insn;
		logic [M_WIDTH-1:0] pc;
		logic insn_pred;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic [M_WIDTH-1:0] insn_pred_target;
	} fetch_bundle_t;

	typedef struct packed {
		op_t op;
		logic [LG_PRF_ENTRIES-1:0] src_a;
		logic [LG_PRF_ENTRIES-1:0] src_b;
		logic [LG_PRF_ENTRIES-1:0] dst;
		logic src_a_valid;
		logic src_b_valid;
		logic dst_valid;
		logic [M_WIDTH-1:0] rvimm;
		logic [M_WIDTH-1:0] jmp_target;
		logic [M_WIDTH-1:0] pc;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic br_pred;
		logic is_br;
		logic is_mem;
		logic is_store;
		logic is_int;
		logic is_cheap_int;
		logic serializing;
		logic must_restart;
	} uop_bundle_t;

endpackage
